// File: core_config_pkg.sv
package core_config_pkg;

    // Datapath and register file widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;
    localparam int CMD_W      = 3;

    // One entry per register address, register 0 included
    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    // Data word as seen by the register file and the ALU
    typedef logic [XLEN - 1 : 0] word_t;

    // ALU result with the carry or borrow on top
    typedef logic [XLEN : 0] wide_word_t;

    // Register index
    typedef logic [REG_ADDR_W - 1 : 0] reg_addr_t;

    // Immediate field of an instruction
    typedef logic [IMM_W - 1 : 0] imm_t;

    // ALU commands, codes 5 to 7 are not defined
    typedef enum logic [CMD_W - 1 : 0] {
        c_ADD = 3'd0,
        c_SUB = 3'd1,
        c_AND = 3'd2,
        c_OR  = 3'd3,
        c_XOR = 3'd4
    } alu_cmd_t;

    // Immediate widened to a full data word, upper bits zero
    function automatic word_t zext_imm(input imm_t imm);
        return {{(XLEN - IMM_W){1'b0}}, imm};
    endfunction

endpackage

// File: issue_if.sv
`timescale 1ns/1ns

interface issue_if;
    import core_config_pkg::*;

    // Operands and command, registered by the issuer
    word_t     arg0;
    word_t     arg1;
    alu_cmd_t  cmd;
    reg_addr_t rd;

    // One cycle strobe, only while busy is low
    logic      start;

    // Status back from the ALU
    logic      busy;
    logic      illegal;

    modport issuer (
        output arg0,
        output arg1,
        output cmd,
        output rd,
        output start,
        input  busy,
        input  illegal
    );

    modport alu (
        input  arg0,
        input  arg1,
        input  cmd,
        input  rd,
        input  start,
        output busy,
        output illegal
    );

endinterface

// File: commit_if.sv
`timescale 1ns/1ns

interface commit_if;
    import core_config_pkg::*;

    // Latched ALU result, held until cleared
    word_t     res;
    reg_addr_t rd;
    logic      valid;
    logic      carry;

    // Returned by the committer in the same cycle as valid
    logic      clear;

    modport alu (
        output res,
        output rd,
        output valid,
        output carry,
        input  clear
    );

    modport committer (
        input  res,
        input  rd,
        input  valid,
        input  carry,
        output clear
    );

endinterface

// File: reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                      clk,
    input  logic                      rst_n,

    // Combinational read ports
    input  core_config_pkg::reg_addr_t i_rs0_addr,
    input  core_config_pkg::reg_addr_t i_rs1_addr,
    output core_config_pkg::word_t     o_rs0_data,
    output core_config_pkg::word_t     o_rs1_data,

    // Write port
    input  logic                      i_wr_en,
    input  core_config_pkg::reg_addr_t i_wr_addr,
    input  core_config_pkg::word_t     i_wr_data
);
    import core_config_pkg::*;

    word_t regs [NUM_REGS];

    // Register 0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rs0_data = regs[i_rs0_addr];
    assign o_rs1_data = regs[i_rs1_addr];

endmodule

// File: issuer.sv
`timescale 1ns/1ns

module issuer (
    input  logic                       clk,
    input  logic                       rst_n,

    // Instruction source
    input  logic                       i_valid,
    input  core_config_pkg::alu_cmd_t  i_cmd,
    input  core_config_pkg::reg_addr_t i_rd,
    input  core_config_pkg::reg_addr_t i_rs0,
    input  core_config_pkg::reg_addr_t i_rs1,
    input  logic                       i_use_imm,
    input  core_config_pkg::imm_t      i_imm,
    output logic                       o_ready,
    output logic                       o_illegal,

    // Register file read ports
    output core_config_pkg::reg_addr_t o_rs0_addr,
    output core_config_pkg::reg_addr_t o_rs1_addr,
    input  core_config_pkg::word_t     i_rs0_data,
    input  core_config_pkg::word_t     i_rs1_data,

    // Towards alu0
    issue_if.issuer                    iss
);
    import core_config_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
    } issue_state_t;

    issue_state_t state;

    // Source addresses go straight to the register file
    assign o_rs0_addr = i_rs0;
    assign o_rs1_addr = i_rs1;

    assign o_ready   = (state == S_IDLE);
    assign iss.start = (state == S_ISSUE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            o_illegal <= 1'b0;
        end else begin
            o_illegal <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_valid) begin
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    // The committer clears at once, so busy falls on this edge
                    if (iss.illegal) begin
                        o_illegal <= 1'b1;
                        state     <= S_IDLE;
                    end else if (iss.busy) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Operand capture on accept
    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            iss.arg0 <= i_rs0_data;
            iss.arg1 <= i_use_imm ? zext_imm(i_imm) : i_rs1_data;
            iss.cmd  <= i_cmd;
            iss.rd   <= i_rd;
        end
    end

endmodule

// File: alu0.sv
`timescale 1ns/1ns

module alu0 (
    input  logic     clk,
    input  logic     rst_n,

    // From the issuer
    issue_if.alu     iss,

    // To the committer
    commit_if.alu    cmt
);
    import core_config_pkg::*;

    wide_word_t tmp_res;
    logic       legal;

    // Extra top bit catches the carry or borrow
    always_comb begin
        tmp_res = '0;
        legal   = 1'b1;
        case (iss.cmd)
            c_ADD: begin
                tmp_res = {1'b0, iss.arg0} + {1'b0, iss.arg1};
            end
            c_SUB: begin
                tmp_res = {1'b0, iss.arg0} - {1'b0, iss.arg1};
            end
            c_AND: begin
                tmp_res = {1'b0, iss.arg0} & {1'b0, iss.arg1};
            end
            c_OR: begin
                tmp_res = {1'b0, iss.arg0} | {1'b0, iss.arg1};
            end
            c_XOR: begin
                tmp_res = {1'b0, iss.arg0} ^ {1'b0, iss.arg1};
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Status flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss.busy    <= 1'b0;
            iss.illegal <= 1'b0;
            cmt.valid   <= 1'b0;
        end else begin
            // Illegal is a single cycle flag
            iss.illegal <= 1'b0;
            if (iss.start) begin
                if (legal) begin
                    iss.busy  <= 1'b1;
                    cmt.valid <= 1'b1;
                end else begin
                    iss.illegal <= 1'b1;
                end
            end else if (cmt.valid && cmt.clear) begin
                iss.busy  <= 1'b0;
                cmt.valid <= 1'b0;
            end
        end
    end

    // Result held until the committer has taken it
    always_ff @(posedge clk) begin
        if (iss.start && legal) begin
            cmt.res   <= tmp_res[XLEN - 1 : 0];
            cmt.carry <= tmp_res[XLEN];
            cmt.rd    <= iss.rd;
        end
    end

endmodule

// File: committer.sv
`timescale 1ns/1ns

module committer (
    input  logic                       clk,
    input  logic                       rst_n,

    // From alu0
    commit_if.committer                cmt,

    // Register file write port
    output logic                       o_wr_en,
    output core_config_pkg::reg_addr_t o_wr_addr,
    output core_config_pkg::word_t     o_wr_data,

    // Write-back report
    output logic                       o_wb_valid,
    output core_config_pkg::reg_addr_t o_wb_rd,
    output core_config_pkg::word_t     o_wb_data,
    output logic                       o_carry
);
    import core_config_pkg::*;

    // Nothing stalls write-back, a result is taken the cycle it appears
    assign cmt.clear = cmt.valid;

    // Same cycle write into the register file
    assign o_wr_en   = cmt.valid;
    assign o_wr_addr = cmt.rd;
    assign o_wr_data = cmt.res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= cmt.valid;
        end
    end

    // Report payload, only meaningful with o_wb_valid
    always_ff @(posedge clk) begin
        if (cmt.valid) begin
            o_wb_rd   <= cmt.rd;
            o_wb_data <= cmt.res;
            o_carry   <= cmt.carry;
        end
    end

endmodule

// File: exec_core_top.sv
`timescale 1ns/1ns

module exec_core_top (
    input  logic                       clk,
    input  logic                       rst_n,

    // Instruction input
    input  logic                       i_valid,
    input  core_config_pkg::alu_cmd_t  i_cmd,
    input  core_config_pkg::reg_addr_t i_rd,
    input  core_config_pkg::reg_addr_t i_rs0,
    input  core_config_pkg::reg_addr_t i_rs1,
    input  logic                       i_use_imm,
    input  core_config_pkg::imm_t      i_imm,
    output logic                       o_ready,

    // Outcome
    output logic                       o_wb_valid,
    output core_config_pkg::reg_addr_t o_wb_rd,
    output core_config_pkg::word_t     o_wb_data,
    output logic                       o_carry,
    output logic                       o_illegal
);
    import core_config_pkg::*;

    reg_addr_t rs0_addr;
    reg_addr_t rs1_addr;
    word_t     rs0_data;
    word_t     rs1_data;

    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    issue_if  iss_bus ();
    commit_if cmt_bus ();

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs0_addr (rs0_addr),
        .i_rs1_addr (rs1_addr),
        .o_rs0_data (rs0_data),
        .o_rs1_data (rs1_data),
        .i_wr_en    (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data)
    );

    issuer u_issuer (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (i_valid),
        .i_cmd      (i_cmd),
        .i_rd       (i_rd),
        .i_rs0      (i_rs0),
        .i_rs1      (i_rs1),
        .i_use_imm  (i_use_imm),
        .i_imm      (i_imm),
        .o_ready    (o_ready),
        .o_illegal  (o_illegal),
        .o_rs0_addr (rs0_addr),
        .o_rs1_addr (rs1_addr),
        .i_rs0_data (rs0_data),
        .i_rs1_data (rs1_data),
        .iss        (iss_bus.issuer)
    );

    alu0 u_alu0 (
        .clk   (clk),
        .rst_n (rst_n),
        .iss   (iss_bus.alu),
        .cmt   (cmt_bus.alu)
    );

    committer u_committer (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmt        (cmt_bus.committer),
        .o_wr_en    (wr_en),
        .o_wr_addr  (wr_addr),
        .o_wr_data  (wr_data),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data),
        .o_carry    (o_carry)
    );

endmodule

// File: tb_exec_core.sv
`timescale 1ns/1ns

module tb_exec_core;
    import core_config_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;
    localparam int NUM_RANDOM     = 200;

    // One instruction with its expected outcome
    typedef struct packed {
        logic [2:0] cmd;
        reg_addr_t  rd;
        reg_addr_t  rs0;
        reg_addr_t  rs1;
        logic       use_imm;
        imm_t       imm;
        logic       exp_illegal;
        word_t      exp_data;
        logic       exp_carry;
    } vec_t;

    logic      clk;
    logic      rst_n;
    logic      i_valid;
    alu_cmd_t  i_cmd;
    reg_addr_t i_rd;
    reg_addr_t i_rs0;
    reg_addr_t i_rs1;
    logic      i_use_imm;
    imm_t      i_imm;
    logic      o_ready;
    logic      o_wb_valid;
    reg_addr_t o_wb_rd;
    word_t     o_wb_data;
    logic      o_carry;
    logic      o_illegal;

    vec_t  vecs [$];
    string vec_names [$];
    word_t model [NUM_REGS];

    exec_core_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (i_valid),
        .i_cmd      (i_cmd),
        .i_rd       (i_rd),
        .i_rs0      (i_rs0),
        .i_rs1      (i_rs1),
        .i_use_imm  (i_use_imm),
        .i_imm      (i_imm),
        .o_ready    (o_ready),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data),
        .o_carry    (o_carry),
        .o_illegal  (o_illegal)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    task automatic value_error(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        stop_run($sformatf("** Error [%s] %s: expected %h, actual %h", name, what, exp, act));
    endtask

    function automatic vec_t make_vec(input int cmd, input int rd, input int rs0,
                                      input int rs1, input int use_imm, input imm_t imm,
                                      input int exp_illegal, input word_t exp_data,
                                      input int exp_carry);
        vec_t v;
        v.cmd         = 3'(cmd);
        v.rd          = reg_addr_t'(rd);
        v.rs0         = reg_addr_t'(rs0);
        v.rs1         = reg_addr_t'(rs1);
        v.use_imm     = (use_imm != 0);
        v.imm         = imm;
        v.exp_illegal = (exp_illegal != 0);
        v.exp_data    = exp_data;
        v.exp_carry   = (exp_carry != 0);
        return v;
    endfunction

    task automatic add_vec(input string name, input int cmd, input int rd, input int rs0,
                           input int rs1, input int use_imm, input imm_t imm,
                           input int exp_illegal, input word_t exp_data, input int exp_carry);
        vecs.push_back(make_vec(cmd, rd, rs0, rs1, use_imm, imm, exp_illegal, exp_data,
                                exp_carry));
        vec_names.push_back(name);
    endtask

    // Name, cmd, rd, rs0, rs1, use_imm, imm, illegal, data, carry
    task automatic fill_table();
        add_vec("reset_read_r0", c_ADD, 1, 0, 0, 0, 16'h0000, 0, 32'h0000_0000, 0);
        add_vec("load_r2", c_ADD, 2, 0, 0, 1, 16'h1234, 0, 32'h0000_1234, 0);
        add_vec("load_r3", c_ADD, 3, 0, 0, 1, 16'hFFFF, 0, 32'h0000_FFFF, 0);
        add_vec("add_r4", c_ADD, 4, 2, 3, 0, 16'h0000, 0, 32'h0001_1233, 0);
        add_vec("sub_r5", c_SUB, 5, 3, 2, 0, 16'h0000, 0, 32'h0000_EDCB, 0);
        add_vec("and_r6", c_AND, 6, 2, 3, 0, 16'h0000, 0, 32'h0000_1234, 0);
        add_vec("or_imm_r7", c_OR, 7, 2, 0, 1, 16'h0F0F, 0, 32'h0000_1F3F, 0);
        add_vec("xor_r8", c_XOR, 8, 3, 2, 0, 16'h0000, 0, 32'h0000_EDCB, 0);
        add_vec("sub_all_ones", c_SUB, 9, 0, 0, 1, 16'h0001, 0, 32'hFFFF_FFFF, 1);
        add_vec("add_carry", c_ADD, 10, 9, 0, 1, 16'h0001, 0, 32'h0000_0000, 1);
        add_vec("sub_borrow", c_SUB, 11, 2, 3, 0, 16'h0000, 0, 32'hFFFF_1235, 1);
        add_vec("and_no_carry", c_AND, 12, 9, 9, 0, 16'h0000, 0, 32'hFFFF_FFFF, 0);
        add_vec("or_no_carry", c_OR, 13, 9, 0, 0, 16'h0000, 0, 32'hFFFF_FFFF, 0);
        add_vec("xor_no_carry", c_XOR, 14, 9, 2, 0, 16'h0000, 0, 32'hFFFF_EDCB, 0);
        add_vec("write_r0", c_ADD, 0, 0, 0, 1, 16'h5A5A, 0, 32'h0000_5A5A, 0);
        add_vec("read_r0", c_OR, 15, 0, 0, 0, 16'h0000, 0, 32'h0000_0000, 0);
        add_vec("illegal_5", 5, 2, 3, 3, 0, 16'h0000, 1, 32'h0000_0000, 0);
        add_vec("illegal_6", 6, 2, 3, 0, 1, 16'h00FF, 1, 32'h0000_0000, 0);
        add_vec("illegal_7", 7, 2, 9, 9, 0, 16'h0000, 1, 32'h0000_0000, 0);
        add_vec("read_r2_kept", c_ADD, 16, 2, 0, 0, 16'h0000, 0, 32'h0000_1234, 0);
    endtask

    // Carry out of an add shows as a wrapped sum, a borrow as a < b
    function automatic logic [32:0] expected_result(input logic [2:0] cmd, input word_t a,
                                                    input word_t b);
        word_t d;
        logic  c;
        c = 1'b0;
        d = '0;
        case (cmd)
            3'd0: begin
                d = a + b;
                c = (d < a);
            end
            3'd1: begin
                d = a - b;
                c = (a < b);
            end
            3'd2: d = a & b;
            3'd3: d = a | b;
            3'd4: d = a ^ b;
            default: d = '0;
        endcase
        return {c, d};
    endfunction

    function automatic vec_t random_vec(input reg_addr_t prev_rd);
        vec_t        v;
        int unsigned sel;
        word_t       b;
        logic [32:0] res;
        sel = $urandom_range(0, 11);
        if (sel > 9) begin
            v.cmd = 3'(5 + $urandom_range(0, 2));
        end else begin
            v.cmd = 3'(sel % 5);
        end
        v.rd = reg_addr_t'($urandom_range(0, 31));
        // Half of the time read the register written just before
        v.rs0     = ($urandom_range(0, 1) == 0) ? prev_rd : reg_addr_t'($urandom_range(0, 31));
        v.rs1     = reg_addr_t'($urandom_range(0, 31));
        v.use_imm = 1'($urandom_range(0, 1));
        v.imm     = 16'($urandom());
        b = v.use_imm ? {16'h0000, v.imm} : model[v.rs1];
        res = expected_result(v.cmd, model[v.rs0], b);
        v.exp_illegal = (v.cmd > 3'd4);
        v.exp_data    = res[31:0];
        v.exp_carry   = res[32];
        return v;
    endfunction

    task automatic drive_instr(input vec_t v);
        i_valid   = 1'b1;
        i_cmd     = alu_cmd_t'(v.cmd);
        i_rd      = v.rd;
        i_rs0     = v.rs0;
        i_rs1     = v.rs1;
        i_use_imm = v.use_imm;
        i_imm     = v.imm;
    endtask

    // Returns just after the accepting edge
    task automatic accept_instr(input string name);
        int cycles;
        cycles = 0;
        while (!o_ready) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run($sformatf("Timeout: %s was never accepted, o_ready stayed low", name));
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_outcome(input string name, input vec_t v);
        int cycles;
        cycles = 0;
        while (!(o_wb_valid || o_illegal)) begin
            assert (!o_ready) else value_error(name, "o_ready in flight", 32'd0, 32'(o_ready));
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run($sformatf("Timeout: no write-back or illegal flag for %s", name));
            end
        end
        assert (cycles == 2) else value_error(name, "outcome latency", 32'd2, 32'(cycles));
        assert (o_ready) else value_error(name, "o_ready", 32'd1, 32'(o_ready));
        assert (o_illegal == v.exp_illegal)
            else value_error(name, "o_illegal", 32'(v.exp_illegal), 32'(o_illegal));
        assert (o_wb_valid == !v.exp_illegal)
            else value_error(name, "o_wb_valid", 32'(!v.exp_illegal), 32'(o_wb_valid));
        if (!v.exp_illegal) begin
            assert (o_wb_rd == v.rd) else value_error(name, "o_wb_rd", 32'(v.rd), 32'(o_wb_rd));
            assert (o_wb_data == v.exp_data)
                else value_error(name, "o_wb_data", v.exp_data, o_wb_data);
            assert (o_carry == v.exp_carry)
                else value_error(name, "o_carry", 32'(v.exp_carry), 32'(o_carry));
        end
        // Outcome is a single cycle pulse
        @(posedge clk);
        #1;
        assert (!o_wb_valid && !o_illegal)
            else stop_run($sformatf("%s: outcome pulse lasted more than one cycle", name));
    endtask

    task automatic update_model(input vec_t v);
        if (!v.exp_illegal && (v.rd != '0)) begin
            model[v.rd] = v.exp_data;
        end
    endtask

    task automatic run_vec(input string name, input vec_t v);
        drive_instr(v);
        accept_instr(name);
        i_valid = 1'b0;
        wait_outcome(name, v);
        update_model(v);
    endtask

    // Second instruction waits on the inputs while the first is in flight
    task automatic check_held_instr();
        vec_t a_v;
        vec_t b_v;
        a_v = make_vec(c_ADD, 17, 0, 0, 1, 16'h0010, 0, 32'h0000_0010, 0);
        b_v = make_vec(c_ADD, 18, 18, 0, 1, 16'h0001, 0, model[18] + 32'd1, 0);
        drive_instr(a_v);
        accept_instr("held_first");
        drive_instr(b_v);
        wait_outcome("held_first", a_v);
        i_valid = 1'b0;
        wait_outcome("held_second", b_v);
        update_model(a_v);
        update_model(b_v);
        run_vec("held_read_back", make_vec(c_OR, 19, 18, 0, 0, 16'h0000, 0, model[18], 0));
    endtask

    initial begin
        vec_t        v;
        reg_addr_t   prev_rd;
        void'($urandom(32'h43af));
        rst_n     = 1'b0;
        i_valid   = 1'b0;
        i_cmd     = c_ADD;
        i_rd      = '0;
        i_rs0     = '0;
        i_rs1     = '0;
        i_use_imm = 1'b0;
        i_imm     = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        fill_table();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        assert (o_ready) else value_error("reset_state", "o_ready", 32'd1, 32'(o_ready));
        assert (!o_wb_valid)
            else value_error("reset_state", "o_wb_valid", 32'd0, 32'(o_wb_valid));
        assert (!o_illegal) else value_error("reset_state", "o_illegal", 32'd0, 32'(o_illegal));

        foreach (vecs[i]) begin
            run_vec(vec_names[i], vecs[i]);
        end
        check_held_instr();

        prev_rd = '0;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            v = random_vec(prev_rd);
            run_vec($sformatf("random_%0d", n), v);
            prev_rd = v.rd;
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: sources.f
core_config_pkg.sv
issue_if.sv
commit_if.sv
reg_file.sv
issuer.sv
alu0.sv
committer.sv
exec_core_top.sv
tb_exec_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_exec_core -o Vtb_exec_core

./obj_dir/Vtb_exec_core 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation ended without a result, see sim.log"
    exit 1
fi
echo "Simulation passed"
